/* filelist.f */
mclPkg.sv
memFuncDecode.sv
cycleRequest.sv
vmaContext.sv
vmaHeld.sv
mclTop.sv
tbMcl.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, result comes from sim.log
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tbMcl -o simMcl \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simMcl > sim.log 2>&1 || true
cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tbMcl.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMcl import mclPkg::*;;

  logic clk = 1'b0;
  logic rstN;
  logic [3:0] memVal;
  logic [8:0] magicVal;
  logic [1:0] vmaSelVal;
  cramFields cram;
  logic [0:12] ad;
  logic [2:0] dramA;
  logic dramB2, testSatisfied, piCycle, ebosSync, specMemCycle;
  logic scdUser, scdPublic, condSelVma, condLoadVmaHeld, vmaBit12;
  pcFlags pcFlagsIn;
  logic diagRead;
  logic [2:0] diagSel;
  vmaReq req;
  vmaCtx ctx;
  logic vmaFetch, mboxCycReq, vmaInc, vmaAdrErr;
  logic [1:12] heldOrPc;
  logic [0:5] diagBus;

  // Reference model state
  logic [3:0] mReq, mCtx;
  logic mFetch, mErr;
  logic [11:0] mHeld;
  logic skipExp, reqEnExp, loadVmaExp, fetchNextExp, errNextExp, mboxExp, incExp;
  logic [3:0] reqNextExp, ctxNextExp;
  logic [11:0] heldOrPcExp;
  logic [5:0] diagExp;

  logic [31:0] lfsr;
  int errCount, passCount, failCount;
  bit checkOn;

  assign cram = {memVal, magicVal, vmaSelVal, 2'b00};

  mclTop dut0 (
    .clk(clk), .rstN(rstN), .cram(cram), .ad(ad), .dramA(dramA), .dramB2(dramB2),
    .testSatisfied(testSatisfied), .piCycle(piCycle), .ebosSync(ebosSync),
    .specMemCycle(specMemCycle), .scdUser(scdUser), .scdPublic(scdPublic),
    .condSelVma(condSelVma), .condLoadVmaHeld(condLoadVmaHeld), .vmaBit12(vmaBit12),
    .pcFlagsIn(pcFlagsIn), .diagRead(diagRead), .diagSel(diagSel), .req(req), .ctx(ctx),
    .vmaFetch(vmaFetch), .mboxCycReq(mboxCycReq), .vmaInc(vmaInc), .vmaAdrErr(vmaAdrErr),
    .heldOrPc(heldOrPc), .diagBus(diagBus)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Request bits in the order AR, ARX, pause, write
  function automatic logic [3:0] nextReqOf(input logic [3:0] mem, input logic [8:0] mg,
                                           input logic [0:12] a, input logic [2:0] da,
                                           input logic skip);
    case (mem)
      memEaCalc: return mg[8:5];
      memAdFunc: return {a[1], a[2], a[3], a[4]};
      memARead: return {da[2], da == 3'd1, da == 3'd7, da == 3'd3 || da == 3'd6 || da == 3'd7};
      memLoadAr: return 4'b1000;
      memRwCycle: return 4'b1001;
      memRpwCycle: return 4'b1011;
      memUncondFetch, memLoadArx: return 4'b0100;
      memWrite, memBWrite: return 4'b0001;
      memCondFetch: return {1'b0, skip, 2'b00};
      default: return 4'b0000;
    endcase
  endfunction

  function automatic logic [5:0] diagOf(input logic rd, input logic [2:0] sel,
                                        input logic [11:0] hp, input logic [3:0] r,
                                        input logic [3:0] c, input logic f, input logic mb);
    if (!rd) return 6'b0;
    case (sel)
      3'd0: return hp[11:6];
      3'd1: return hp[5:0];
      3'd2: return {r, c[1:0]};
      3'd3: return {c, f, mb};
      default: return 6'b0;
    endcase
  endfunction

  always_comb begin
    skipExp = memVal == memCondFetch && magicVal[3] && testSatisfied;
    reqEnExp = memVal != memNop && !(memVal == memBWrite && !dramB2);
    loadVmaExp = vmaSelVal != 2'b00 && !skipExp;
    reqNextExp = nextReqOf(memVal, magicVal, ad, dramA, skipExp);
    fetchNextExp = skipExp || (memVal == memARead && dramA == 3'd1) ||
                   memVal == memUncondFetch;
    ctxNextExp[3] = (scdUser && (mFetch || (specMemCycle && magicVal[7])) &&
                     !(specMemCycle && magicVal[6])) || (memVal == memAdFunc && ad[5]);
    ctxNextExp[2] = (scdPublic && mFetch) || (memVal == memAdFunc && ad[6]);
    ctxNextExp[1] = memVal == memAdFunc && ad[7];
    ctxNextExp[0] = (memVal == memAdFunc && ad[8]) || memVal == memEaCalc;
    errNextExp = vmaBit12 || ((memVal == memEaCalc || memVal == memRegFunc) &&
                              ((|ad[6:11]) || !ad[12]));
    mboxExp = memVal[3] || (memVal == memARead && dramA != 3'd0 && dramA != 3'd2) ||
              (memVal == memCondFetch && !piCycle) || (memVal == memRegFunc && ebosSync);
    incExp = skipExp && !piCycle;
    heldOrPcExp = condSelVma ? mHeld : pcFlagsIn;
    diagExp = diagOf(diagRead, diagSel, heldOrPcExp, mReq, mCtx, mFetch, mboxExp);
  end

  always @(posedge clk) begin
    if (!rstN) begin
      mReq <= '0;
      mCtx <= '0;
      mFetch <= 1'b0;
      mErr <= 1'b0;
      mHeld <= '0;
    end else begin
      if (reqEnExp) begin
        mReq <= reqNextExp;
        mFetch <= fetchNextExp;
      end
      if (loadVmaExp || specMemCycle) mCtx <= ctxNextExp;
      if (loadVmaExp) mErr <= errNextExp;
      if (condLoadVmaHeld || memVal == memRestoreVma) mHeld <= {mReq, mCtx, mFetch, 3'b000};
    end
  end

  task automatic checkVal(input string name, input logic [11:0] got, input logic [11:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errCount++;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (checkOn) begin
      checkVal("req", 12'(req), 12'(mReq));
      checkVal("ctx", 12'(ctx), 12'(mCtx));
      checkVal("vmaFetch", 12'(vmaFetch), 12'(mFetch));
      checkVal("vmaAdrErr", 12'(vmaAdrErr), 12'(mErr));
      checkVal("mboxCycReq", 12'(mboxCycReq), 12'(mboxExp));
      checkVal("vmaInc", 12'(vmaInc), 12'(incExp));
      checkVal("heldOrPc", heldOrPc, heldOrPcExp);
      checkVal("diagBus", 12'(diagBus), 12'(diagExp));
    end
  end

  task automatic randBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle();
    memVal = memNop;
    magicVal = '0;
    vmaSelVal = 2'b00;
    testSatisfied = 1'b0;
    piCycle = 1'b0;
    ebosSync = 1'b0;
    specMemCycle = 1'b0;
    scdUser = 1'b0;
    scdPublic = 1'b0;
    condLoadVmaHeld = 1'b0;
    vmaBit12 = 1'b0;
  endtask

  task automatic randomInputs();
    logic [31:0] v;
    randBits(9, v);
    magicVal = v[8:0];
    randBits(13, v);
    ad = v[12:0];
    randBits(3, v);
    dramA = v[2:0];
    randBits(10, v);
    {dramB2, testSatisfied, piCycle, ebosSync} = v[3:0];
    vmaSelVal = v[5:4];
    {scdUser, scdPublic} = v[7:6];
    {specMemCycle, vmaBit12} = v[9:8];
  endtask

  task automatic endTest(input string name, input int errBefore);
    if (errCount == errBefore) begin
      passCount++;
      $display("test %s: ok", name);
    end else begin
      failCount++;
      $display("test %s: %0d mismatches", name, errCount - errBefore);
    end
  endtask

  initial begin
    #100000;
    $display("simulation did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int errBefore;
    int waits;
    logic [31:0] v;
    lfsr = 32'h7174_1d2a;
    errCount = 0;
    passCount = 0;
    failCount = 0;
    checkOn = 1'b0;
    rstN = 1'b0;
    ad = '0;
    dramA = '0;
    dramB2 = 1'b0;
    condSelVma = 1'b0;
    pcFlagsIn = '0;
    diagRead = 1'b0;
    diagSel = '0;
    idle();
    @(posedge clk);
    checkOn = 1'b1;
    repeat (2) @(posedge clk);
    #1 rstN = 1'b1;

    errBefore = errCount;
    checkVal("req after reset", 12'(req), 12'd0);
    checkVal("ctx after reset", 12'(ctx), 12'd0);
    checkVal("vmaFetch after reset", 12'(vmaFetch), 12'd0);
    checkVal("vmaAdrErr after reset", 12'(vmaAdrErr), 12'd0);
    endTest("reset values", errBefore);

    errBefore = errCount;
    for (int code = 0; code < 16; code++) begin
      for (int k = 0; k < 8; k++) begin
        randomInputs();
        memVal = code[3:0];
        nextCycle();
      end
    end
    idle();
    nextCycle();
    endTest("request decode", errBefore);

    // Known context that the skip must leave alone
    errBefore = errCount;
    memVal = memAdFunc;
    vmaSelVal = 2'b01;
    ad = 13'b00000_1111_0000;
    nextCycle();
    idle();
    memVal = memCondFetch;
    magicVal = 9'h008;
    testSatisfied = 1'b1;
    vmaSelVal = 2'b01;
    waits = 0;
    do begin
      nextCycle();
      idle();
      waits++;
    end while (!vmaFetch && waits < 100);
    if (!vmaFetch) begin
      $display("timeout: vmaFetch never rose after the conditional fetch");
      $display("TEST FAIL");
      $finish;
    end
    checkVal("vmaFetch delay", 12'(waits), 12'd1);
    endTest("conditional fetch skip", errBefore);

    errBefore = errCount;
    for (int k = 0; k < 16; k++) begin
      idle();
      randBits(13, v);
      ad = v[12:0];
      memVal = memAdFunc;
      vmaSelVal = 2'b10;
      nextCycle();
    end
    for (int k = 0; k < 16; k++) begin
      idle();
      randBits(13, v);
      ad = v[12:0];
      randBits(1, v);
      // Clear the section bits half the time so both results appear
      if (v[0]) ad[6:11] = '0;
      randBits(9, v);
      magicVal = v[8:0];
      memVal = memEaCalc;
      vmaSelVal = 2'b01;
      nextCycle();
    end
    idle();
    nextCycle();
    endTest("context and address error", errBefore);

    errBefore = errCount;
    for (int k = 0; k < 8; k++) begin
      idle();
      randBits(13, v);
      ad = v[12:0];
      memVal = k[0] ? memRpwCycle : memAdFunc;
      vmaSelVal = 2'b01;
      nextCycle();
      idle();
      if (k == 5) memVal = memRestoreVma;
      else condLoadVmaHeld = 1'b1;
      nextCycle();
      idle();
      randBits(12, v);
      pcFlagsIn = v[11:0];
      condSelVma = 1'b1;
      nextCycle();
      condSelVma = 1'b0;
      nextCycle();
    end
    endTest("held register", errBefore);

    errBefore = errCount;
    idle();
    memVal = memUncondFetch;
    vmaSelVal = 2'b01;
    ad = 13'b00000_1011_0001;
    nextCycle();
    idle();
    condLoadVmaHeld = 1'b1;
    nextCycle();
    idle();
    diagRead = 1'b1;
    for (int sel = 0; sel < 8; sel++) begin
      for (int cs = 0; cs < 2; cs++) begin
        diagSel = sel[2:0];
        condSelVma = cs[0];
        memVal = cs[0] ? memWrite : memNop;
        randBits(12, v);
        pcFlagsIn = v[11:0];
        nextCycle();
      end
    end
    idle();
    diagRead = 1'b0;
    for (int sel = 0; sel < 8; sel++) begin
      diagSel = sel[2:0];
      nextCycle();
    end
    endTest("diagnostic bus", errBefore);

    $display("tests passed %0d, tests failed %0d, mismatches %0d",
             passCount, failCount, errCount);
    if (failCount == 0 && errCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mclTop.sv */
`timescale 1ns/1ps
`default_nettype none

module mclTop import mclPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  cramFields           cram,
  input  logic [0:adW-1]      ad,
  input  logic [2:0]          dramA,
  input  logic                dramB2,
  input  logic                testSatisfied,
  input  logic                piCycle,
  input  logic                ebosSync,
  input  logic                specMemCycle,
  input  logic                scdUser,
  input  logic                scdPublic,
  input  logic                condSelVma,
  input  logic                condLoadVmaHeld,
  input  logic                vmaBit12,
  input  pcFlags              pcFlagsIn,
  input  logic                diagRead,
  input  logic [diagSelW-1:0] diagSel,
  output vmaReq               req,
  output vmaCtx               ctx,
  output logic                vmaFetch,
  output logic                mboxCycReq,
  output logic                vmaInc,
  output logic                vmaAdrErr,
  output logic [1:12]         heldOrPc,
  output logic [0:5]          diagBus
);

  memFunc fn;
  logic reqEn;
  logic loadVma;
  logic skipSatisfied;

  memFuncDecode decode0 (
    .cram(cram), .testSatisfied(testSatisfied), .piCycle(piCycle), .dramB2(dramB2),
    .fn(fn), .reqEn(reqEn), .loadVma(loadVma), .skipSatisfied(skipSatisfied),
    .vmaInc(vmaInc)
  );

  cycleRequest cycReq0 (
    .clk(clk), .rstN(rstN), .fn(fn), .reqEn(reqEn), .skipSatisfied(skipSatisfied),
    .magic(cram.magic), .adFunc(ad[1:4]), .dramA(dramA), .piCycle(piCycle),
    .ebosSync(ebosSync), .req(req), .vmaFetch(vmaFetch), .mboxCycReq(mboxCycReq)
  );

  vmaContext ctx0 (
    .clk(clk), .rstN(rstN), .fn(fn), .loadVma(loadVma), .specMemCycle(specMemCycle),
    .magic(cram.magic), .ad(ad), .scdUser(scdUser), .scdPublic(scdPublic),
    .vmaBit12(vmaBit12), .fetch(vmaFetch), .ctx(ctx), .vmaAdrErr(vmaAdrErr)
  );

  vmaHeld held0 (
    .clk(clk), .rstN(rstN), .fn(fn), .condLoadVmaHeld(condLoadVmaHeld), .req(req),
    .ctx(ctx), .vmaFetch(vmaFetch), .mboxCycReq(mboxCycReq), .condSelVma(condSelVma),
    .pcFlagsIn(pcFlagsIn), .diagRead(diagRead), .diagSel(diagSel),
    .heldOrPc(heldOrPc), .diagBus(diagBus)
  );

endmodule

`default_nettype wire

/* vmaHeld.sv */
`timescale 1ns/1ps
`default_nettype none

module vmaHeld import mclPkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  memFunc              fn,
  input  logic                condLoadVmaHeld,
  input  vmaReq               req,
  input  vmaCtx               ctx,
  input  logic                vmaFetch,
  input  logic                mboxCycReq,
  input  logic                condSelVma,
  input  pcFlags              pcFlagsIn,
  input  logic                diagRead,
  input  logic [diagSelW-1:0] diagSel,
  output logic [1:12]         heldOrPc,
  output logic [0:5]          diagBus
);

  heldWord held;
  logic loadHeld;

  assign loadHeld = condLoadVmaHeld | fn.restoreVma;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      held <= '0;
    end else if (loadHeld) begin
      held.req <= req;
      held.ctx <= ctx;
      held.fetch <= vmaFetch;
      // No map, cache or paging state in this slice
      held.map <= 1'b0;
      held.uncached <= 1'b0;
      held.unpaged <= 1'b0;
    end
  end

  assign heldOrPc = condSelVma ? held : pcFlagsIn;

  // Diagnostic read mux
  always_comb begin
    diagBus = '0;
    if (diagRead) begin
      case (diagSel)
        3'd0: diagBus = heldOrPc[1:6];
        3'd1: diagBus = heldOrPc[7:12];
        3'd2: diagBus = {req, ctx[1:0]};
        3'd3: diagBus = {ctx, vmaFetch, mboxCycReq};
        default: diagBus = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* vmaContext.sv */
`timescale 1ns/1ps
`default_nettype none

module vmaContext import mclPkg::*; (
  input  logic           clk,
  input  logic           rstN,
  input  memFunc         fn,
  input  logic           loadVma,
  input  logic           specMemCycle,
  input  magicWord       magic,
  input  logic [0:adW-1] ad,
  input  logic           scdUser,
  input  logic           scdPublic,
  input  logic           vmaBit12,
  input  logic           fetch,
  output vmaCtx          ctx,
  output logic           vmaAdrErr
);

  logic kernelCycle;
  logic specExec;
  logic userEn;
  logic publicEn;
  logic prevEn;
  logic extEn;
  logic vmaLong;
  logic adrErr;

  // Special cycle flags come from the magic field
  assign kernelCycle = specMemCycle & magic.specView.kernel;
  assign specExec = specMemCycle & magic.specView.exec;

  always_comb begin
    userEn = (scdUser & (fetch | kernelCycle) & ~specExec) |
             (fn.adFunc & ad[5]);
    publicEn = (scdPublic & fetch) | (fn.adFunc & ad[6]);
    prevEn = fn.adFunc & ad[7];
    extEn = (fn.adFunc & ad[8]) | fn.eaCalc;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ctx <= '0;
    end else if (loadVma | specMemCycle) begin
      ctx.user <= userEn;
      ctx.public <= publicEn;
      ctx.previous <= prevEn;
      ctx.extended <= extEn;
    end
  end

  // Long address must stay within section bounds
  assign vmaLong = fn.eaCalc | fn.regFunc;
  assign adrErr = vmaLong & ~fn.adFunc & ((|ad[6:11]) | ~ad[12]);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      vmaAdrErr <= 1'b0;
    end else if (loadVma) begin
      vmaAdrErr <= vmaBit12 | adrErr;
    end
  end

endmodule

`default_nettype wire

/* cycleRequest.sv */
`timescale 1ns/1ps
`default_nettype none

module cycleRequest import mclPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  memFunc     fn,
  input  logic       reqEn,
  input  logic       skipSatisfied,
  input  magicWord   magic,
  input  logic [0:3] adFunc,
  input  logic [2:0] dramA,
  input  logic       piCycle,
  input  logic       ebosSync,
  output vmaReq      req,
  output logic       vmaFetch,
  output logic       mboxCycReq
);

  logic [0:3] gatedMagic;
  logic [0:3] gatedAd;
  logic aReadHi;
  logic aRead1;
  logic aRead7;
  logic aRead367;
  logic aReadCyc;
  logic rwOrRpw;
  logic topCode;
  logic fetchEn;
  vmaReq reqNext;

  always_comb begin
    gatedMagic = {4{fn.eaCalc}} & {magic.eaView.loadAr, magic.eaView.loadArx,
                                   magic.eaView.pause, magic.eaView.write};
    gatedAd = {4{fn.adFunc}} & adFunc;
  end

  // Address read decodes of the dispatch A field
  always_comb begin
    aReadHi = fn.aRead & dramA[2];
    aRead1 = fn.aRead & (dramA == 3'd1);
    aRead7 = fn.aRead & (dramA == 3'd7);
    aRead367 = fn.aRead & ((dramA == 3'd3) | (dramA == 3'd6) | (dramA == 3'd7));
    aReadCyc = fn.aRead & (dramA != 3'd0) & (dramA != 3'd2);
  end

  assign rwOrRpw = fn.rwCycle | fn.rpwCycle;
  assign fetchEn = skipSatisfied | aRead1 | fn.uncondFetch;

  always_comb begin
    reqNext.loadAr = gatedMagic[0] | gatedAd[0] | aReadHi | fn.loadAr | rwOrRpw;
    reqNext.loadArx = gatedMagic[1] | gatedAd[1] | fetchEn | fn.loadArx;
    reqNext.pause = gatedMagic[2] | gatedAd[2] | aRead7 | fn.rpwCycle;
    reqNext.write = gatedMagic[3] | gatedAd[3] | aRead367 | fn.bWrite |
                    rwOrRpw | fn.write;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      req <= '0;
      vmaFetch <= 1'b0;
    end else if (reqEn) begin
      req <= reqNext;
      vmaFetch <= fetchEn;
    end
  end

  assign topCode = fn.uncondFetch | fn.write | fn.rpwCycle | fn.rwCycle |
                   fn.loadArx | fn.loadAr | fn.eaCalc | fn.adFunc;

  // Register functions go to the MBOX only on EBOX sync
  assign mboxCycReq = topCode | aReadCyc | (fn.condFetch & ~piCycle) |
                      (ebosSync & fn.regFunc);

endmodule

`default_nettype wire

/* memFuncDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module memFuncDecode import mclPkg::*; (
  input  cramFields cram,
  input  logic      testSatisfied,
  input  logic      piCycle,
  input  logic      dramB2,
  output memFunc    fn,
  output logic      reqEn,
  output logic      loadVma,
  output logic      skipSatisfied,
  output logic      vmaInc
);

  logic [7:0] lo;
  logic [7:0] hi;
  logic condJump;

  function automatic logic [7:0] dec3to8(input logic en, input logic [2:0] sel);
    dec3to8 = en ? (8'b1 << sel) : 8'b0;
  endfunction

  // Two 3-to-8 decoders split on the top bit
  assign lo = dec3to8(~cram.mem[memFieldW-1], cram.mem[2:0]);
  assign hi = dec3to8(cram.mem[memFieldW-1], cram.mem[2:0]);

  always_comb begin
    fn.regFunc = lo[memRegFunc[2:0]];
    fn.condFetch = lo[memCondFetch[2:0]];
    fn.bWrite = lo[memBWrite[2:0]];
    fn.aRead = lo[memARead[2:0]];
    fn.restoreVma = lo[memRestoreVma[2:0]];
    fn.mbWait = lo[memMbWait[2:0]];
    fn.arlInd = lo[memArlInd[2:0]];
    fn.uncondFetch = hi[memUncondFetch[2:0]];
    fn.write = hi[memWrite[2:0]];
    fn.rpwCycle = hi[memRpwCycle[2:0]];
    fn.rwCycle = hi[memRwCycle[2:0]];
    fn.loadArx = hi[memLoadArx[2:0]];
    fn.loadAr = hi[memLoadAr[2:0]];
    fn.eaCalc = hi[memEaCalc[2:0]];
    fn.adFunc = hi[memAdFunc[2:0]];
  end

  assign condJump = fn.condFetch & cram.magic.eaView.condJump;
  assign skipSatisfied = condJump & testSatisfied;
  assign vmaInc = skipSatisfied & ~piCycle;

  // B write only requests when the dispatch allows it
  assign reqEn = ~lo[memNop[2:0]] & ~(fn.bWrite & ~dramB2);
  assign loadVma = (|cram.vmaSel) & ~skipSatisfied;

endmodule

`default_nettype wire

/* mclPkg.sv */
`default_nettype none

package mclPkg;

  localparam int memFieldW = 4;
  localparam int magicW = 9;
  localparam int adW = 13;
  localparam int diagSelW = 3;

  // Memory function codes, top bit clear
  localparam logic [memFieldW-1:0] memNop = 4'h0;
  localparam logic [memFieldW-1:0] memRegFunc = 4'h1;
  localparam logic [memFieldW-1:0] memCondFetch = 4'h2;
  localparam logic [memFieldW-1:0] memBWrite = 4'h3;
  localparam logic [memFieldW-1:0] memARead = 4'h4;
  localparam logic [memFieldW-1:0] memRestoreVma = 4'h5;
  localparam logic [memFieldW-1:0] memMbWait = 4'h6;
  localparam logic [memFieldW-1:0] memArlInd = 4'h7;

  // Top bit set, each one starts an MBOX cycle
  localparam logic [memFieldW-1:0] memUncondFetch = 4'h8;
  localparam logic [memFieldW-1:0] memWrite = 4'h9;
  localparam logic [memFieldW-1:0] memRpwCycle = 4'ha;
  localparam logic [memFieldW-1:0] memRwCycle = 4'hb;
  localparam logic [memFieldW-1:0] memLoadArx = 4'hc;
  localparam logic [memFieldW-1:0] memLoadAr = 4'hd;
  localparam logic [memFieldW-1:0] memEaCalc = 4'he;
  localparam logic [memFieldW-1:0] memAdFunc = 4'hf;

  // Field order follows the decoder outputs, high code first
  typedef struct packed {
    logic adFunc;
    logic eaCalc;
    logic loadAr;
    logic loadArx;
    logic rwCycle;
    logic rpwCycle;
    logic write;
    logic uncondFetch;
    logic arlInd;
    logic mbWait;
    logic restoreVma;
    logic aRead;
    logic bWrite;
    logic condFetch;
    logic regFunc;
  } memFunc;

  typedef union packed {
    struct packed {
      logic loadAr;
      logic loadArx;
      logic pause;
      logic write;
      logic userOvr;
      logic condJump;
      logic [magicW-7:0] spare;
    } eaView;
    struct packed {
      logic fetch;
      logic kernel;
      logic exec;
      logic noMap;
      logic upt;
      logic ept;
      logic cache;
      logic phys;
      logic spare;
    } specView;
  } magicWord;

  typedef struct packed {
    logic [memFieldW-1:0] mem;
    magicWord magic;
    logic [1:0] vmaSel;
    logic [1:0] sh;
  } cramFields;

  typedef struct packed {
    logic loadAr;
    logic loadArx;
    logic pause;
    logic write;
  } vmaReq;

  typedef struct packed {
    logic user;
    logic public;
    logic previous;
    logic extended;
  } vmaCtx;

  typedef struct packed {
    logic cry0;
    logic cry1;
    logic fov;
    logic fpd;
    logic user;
    logic userIot;
    logic public;
    logic adrBrkInh;
    logic trapReq2;
    logic trapReq1;
    logic fxu;
    logic divChk;
  } pcFlags;

  typedef struct packed {
    vmaReq req;
    vmaCtx ctx;
    logic fetch;
    logic map;
    logic uncached;
    logic unpaged;
  } heldWord;

endpackage

`default_nettype wire
